//--- hdl/mips_exec_pkg.sv
package mips_exec_pkg;

	localparam int xlen = 32;             // Data path width
	localparam int shamt_w = 5;           // Shift amount width
	localparam int muldiv_cycles = 32;    // One quotient or product bit per cycle
	localparam int md_cnt_w = $clog2(muldiv_cycles + 1);

	// Operation codes, numbered as on the existing ALU control bus
	typedef enum logic [4:0] {
		op_and   = 5'd0,
		op_or    = 5'd1,
		op_xor   = 5'd2,
		op_addu  = 5'd3,
		op_subu  = 5'd4,
		op_sltu  = 5'd5,
		op_slt   = 5'd6,
		op_multu = 5'd7,
		op_mult  = 5'd8,
		op_sll   = 5'd9,                  // Amount from b[10:6]
		op_sllv  = 5'd10,                 // Amount from b[4:0]
		op_sra   = 5'd11,
		op_srl   = 5'd12,
		op_srav  = 5'd13,
		op_srlv  = 5'd14,
		op_div   = 5'd15,
		op_divu  = 5'd16,
		op_mfhi  = 5'd17,
		op_mflo  = 5'd18,
		op_lui   = 5'd19
	} alu_op_e;

	typedef enum logic [2:0] {
		br_beq  = 3'd0,                   // a == b
		br_bne  = 3'd1,                   // a != b
		br_blez = 3'd2,                   // Signed a <= 0
		br_bgtz = 3'd3,                   // Signed a > 0
		br_bltz = 3'd4,                   // Signed a < 0
		br_bgez = 3'd5                    // Signed a >= 0
	} branch_op_e;

	typedef enum logic [1:0] {
		md_idle = 2'd0,
		md_run  = 2'd1,                   // Iterating
		md_fix  = 2'd2                    // Final sign correction
	} md_state_e;

endpackage

//--- hdl/alu_core.sv
`timescale 1ns/1ps

module alu_core
	import mips_exec_pkg::*;
(
	input  alu_op_e          op,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	input  logic [xlen-1:0]  hi,
	input  logic [xlen-1:0]  lo,
	output logic [xlen-1:0]  y,
	output logic             zero
);

	logic [xlen-1:0] sum;
	logic [xlen-1:0] diff;
	logic            lt_signed;
	logic            lt_unsigned;

	assign sum = a + b;
	assign diff = a - b;

	// Differing signs decide the signed compare on their own
	always_comb begin
		if (a[xlen-1] != b[xlen-1]) begin
			lt_signed = a[xlen-1];
		end else begin
			lt_signed = diff[xlen-1];
		end
	end

	assign lt_unsigned = (a < b);

	always_comb begin
		case (op)
			op_and: begin
				y = a & b;
			end
			op_or: begin
				y = a | b;
			end
			op_xor: begin
				y = a ^ b;
			end
			op_addu: begin
				y = sum;                      // No overflow trap
			end
			op_subu: begin
				y = diff;
			end
			op_slt: begin
				y = {{(xlen-1){1'b0}}, lt_signed};
			end
			op_sltu: begin
				y = {{(xlen-1){1'b0}}, lt_unsigned};
			end
			op_lui: begin
				y = {b[15:0], 16'h0000};      // Immediate into upper half
			end
			op_mfhi: begin
				y = hi;
			end
			op_mflo: begin
				y = lo;
			end
			default: begin
				y = '0;                       // Shifts and mul/div start codes
			end
		endcase
	end

	assign zero = (y == '0);

endmodule

//--- hdl/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter
	import mips_exec_pkg::*;
(
	input  alu_op_e          op,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	output logic [xlen-1:0]  y
);

	logic               is_shift;
	logic               is_left;
	logic               is_arith;
	logic               is_var;
	logic               fill;
	logic [shamt_w-1:0] shamt;
	logic [xlen-1:0]    sh;

	function automatic logic [xlen-1:0] bit_rev(input logic [xlen-1:0] v);
		logic [xlen-1:0] r;
		for (int i = 0; i < xlen; i++) begin
			r[i] = v[xlen-1-i];
		end
		return r;
	endfunction

	assign is_shift = op inside {op_sll, op_sllv, op_srl, op_srlv, op_sra, op_srav};
	assign is_left = op inside {op_sll, op_sllv};
	assign is_arith = op inside {op_sra, op_srav};
	assign is_var = op inside {op_sllv, op_srlv, op_srav};

	assign shamt = is_var ? b[shamt_w-1:0] : b[10:6];   // shamt field for immediate forms
	assign fill = is_arith & a[xlen-1];

	// Left shifts run through the right shifter on reversed bits
	always_comb begin
		sh = is_left ? bit_rev(a) : a;
		if (shamt[0]) begin
			sh = {fill, sh[xlen-1:1]};
		end
		if (shamt[1]) begin
			sh = {{2{fill}}, sh[xlen-1:2]};
		end
		if (shamt[2]) begin
			sh = {{4{fill}}, sh[xlen-1:4]};
		end
		if (shamt[3]) begin
			sh = {{8{fill}}, sh[xlen-1:8]};
		end
		if (shamt[4]) begin
			sh = {{16{fill}}, sh[xlen-1:16]};
		end
	end

	always_comb begin
		if (!is_shift) begin
			y = '0;
		end else if (is_left) begin
			y = bit_rev(sh);
		end else begin
			y = sh;
		end
	end

endmodule

//--- hdl/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit
	import mips_exec_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  alu_op_e          op,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	output logic [xlen-1:0]  hi,
	output logic [xlen-1:0]  lo,
	output logic             busy,
	output logic             done
);

	md_state_e           state;
	logic [md_cnt_w-1:0] cnt;
	alu_op_e             op_r;
	logic                sign_a_r;             // Set only for signed ops
	logic                sign_b_r;
	logic [xlen-1:0]     d_r;                  // Multiplicand or divisor magnitude
	logic [2*xlen-1:0]   p_r;                  // Product, or {remainder, quotient}

	logic                is_md_op;
	logic                is_signed_op;
	logic                accept;
	logic                run_div;
	logic [xlen-1:0]     mag_a;
	logic [xlen-1:0]     mag_b;
	logic [xlen:0]       add_sum;
	logic [xlen:0]       rem_sh;
	logic [xlen:0]       rem_diff;
	logic [2*xlen-1:0]   step_mul;
	logic [2*xlen-1:0]   step_div;
	logic [xlen-1:0]     quo_f;
	logic [xlen-1:0]     rem_f;
	logic [2*xlen-1:0]   fixed;

	assign is_md_op = op inside {op_mult, op_multu, op_div, op_divu};
	assign is_signed_op = op inside {op_mult, op_div};
	assign accept = start && is_md_op && (state == md_idle);
	assign run_div = op_r inside {op_div, op_divu};

	assign mag_a = (is_signed_op && a[xlen-1]) ? -a : a;
	assign mag_b = (is_signed_op && b[xlen-1]) ? -b : b;

	// Shift-and-add, low bit of the multiplier decides the add
	assign add_sum = {1'b0, p_r[2*xlen-1:xlen]} + (p_r[0] ? {1'b0, d_r} : '0);
	assign step_mul = {add_sum, p_r[xlen-1:1]};

	// Restoring divide, dividend bits shift up into the remainder
	assign rem_sh = {p_r[2*xlen-1:xlen], p_r[xlen-1]};
	assign rem_diff = rem_sh - {1'b0, d_r};
	assign step_div = rem_diff[xlen] ?
		{rem_sh[xlen-1:0], p_r[xlen-2:0], 1'b0} :
		{rem_diff[xlen-1:0], p_r[xlen-2:0], 1'b1};

	// Remainder follows the dividend, quotient the sign product
	assign quo_f = (sign_a_r ^ sign_b_r) ? -p_r[xlen-1:0] : p_r[xlen-1:0];
	assign rem_f = sign_a_r ? -p_r[2*xlen-1:xlen] : p_r[2*xlen-1:xlen];

	always_comb begin
		if (run_div) begin
			fixed = {rem_f, quo_f};
		end else if (sign_a_r ^ sign_b_r) begin
			fixed = -p_r;
		end else begin
			fixed = p_r;
		end
	end

	assign busy = (state != md_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= md_idle;
			cnt <= '0;
			op_r <= op_multu;
			done <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				md_idle: begin
					if (accept) begin
						state <= md_run;
						cnt <= '0;
						op_r <= op;
					end
				end
				md_run: begin
					cnt <= cnt + md_cnt_w'(1);
					if (cnt == md_cnt_w'(muldiv_cycles - 1)) begin
						state <= md_fix;
					end
				end
				md_fix: begin
					{hi, lo} <= fixed;           // Result lands with done
					done <= 1'b1;
					state <= md_idle;
				end
				default: begin
					state <= md_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sign_a_r <= is_signed_op & a[xlen-1];
			sign_b_r <= is_signed_op & b[xlen-1];
			d_r <= mag_b;
			p_r <= {{xlen{1'b0}}, mag_a};    // Multiplier or dividend in low half
		end else if (state == md_run) begin
			p_r <= run_div ? step_div : step_mul;
		end
	end

	// A start during an operation must not restart it
	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		(start && busy) |=> ($stable(op_r) && (cnt != '0)))
		else $error("muldiv restarted by start while busy");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("muldiv done held longer than one cycle");

	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (!busy && $past(busy)))
		else $error("muldiv done without busy falling");

endmodule

//--- hdl/branch_compare.sv
`timescale 1ns/1ps

module branch_compare
	import mips_exec_pkg::*;
(
	input  branch_op_e       br_op,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	output logic             taken
);

	logic eq;
	logic a_neg;
	logic a_zero;

	assign eq = (a == b);
	assign a_neg = a[xlen-1];
	assign a_zero = (a == '0);

	always_comb begin
		case (br_op)
			br_beq:  taken = eq;
			br_bne:  taken = !eq;
			br_blez: taken = a_neg | a_zero;
			br_bgtz: taken = !a_neg & !a_zero;
			br_bltz: taken = a_neg;
			br_bgez: taken = !a_neg;
			default: taken = 1'b0;           // Codes 6 and 7 unused
		endcase
	end

	// Only defined branch codes may reach the comparator
	always_comb begin
		a_br_op_known: assert (br_op inside {br_beq, br_bne, br_blez, br_bgtz, br_bltz, br_bgez})
			else $error("branch_compare got undefined br_op %0d", br_op);
	end

endmodule

//--- hdl/mips_execute.sv
`timescale 1ns/1ps

module mips_execute
	import mips_exec_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  alu_op_e          op,
	input  logic [xlen-1:0]  a,
	input  logic [xlen-1:0]  b,
	input  logic             start,
	input  branch_op_e       br_op,
	output logic [xlen-1:0]  y,
	output logic             zero,
	output logic             taken,
	output logic             md_busy,
	output logic             md_done
);

	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] shift_y;
	logic [xlen-1:0] hi;
	logic [xlen-1:0] lo;
	logic            is_shift;

	alu_core alu_core_inst (
		.op   (op),
		.a    (a),
		.b    (b),
		.hi   (hi),
		.lo   (lo),
		.y    (alu_y),
		.zero (zero)                          // Flag tracks the ALU result
	);

	barrel_shifter barrel_shifter_inst (
		.op (op),
		.a  (a),
		.b  (b),
		.y  (shift_y)
	);

	muldiv_unit muldiv_unit_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.op    (op),
		.a     (a),
		.b     (b),
		.hi    (hi),
		.lo    (lo),
		.busy  (md_busy),
		.done  (md_done)
	);

	branch_compare branch_compare_inst (
		.br_op (br_op),
		.a     (a),
		.b     (b),
		.taken (taken)
	);

	assign is_shift = op inside {op_sll, op_sllv, op_srl, op_srlv, op_sra, op_srav};
	assign y = is_shift ? shift_y : alu_y;

endmodule

//--- tb/tb_mips_execute.sv
`timescale 1ns/1ps

module tb_mips_execute
	import mips_exec_pkg::*;
();

	typedef struct packed {
		alu_op_e          op;
		branch_op_e       br;
		logic [xlen-1:0]  a;
		logic [xlen-1:0]  b;
		logic             start;
		logic             poke;                // Extra start pulse while busy
		logic [xlen-1:0]  y;
		logic             zero;
		logic             taken;
		logic [xlen-1:0]  hi;
		logic [xlen-1:0]  lo;
	} row_t;

	logic            clk = 1'b0;
	logic            rst_n;
	alu_op_e         op;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic            start;
	branch_op_e      br_op;
	logic [xlen-1:0] y;
	logic            zero;
	logic            taken;
	logic            md_busy;
	logic            md_done;

	row_t            rows [$];
	int              errors;
	int              checks;
	logic [xlen-1:0] run_hi;                   // HI/LO as the model expects them
	logic [xlen-1:0] run_lo;

	mips_execute mips_execute_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.op      (op),
		.a       (a),
		.b       (b),
		.start   (start),
		.br_op   (br_op),
		.y       (y),
		.zero    (zero),
		.taken   (taken),
		.md_busy (md_busy),
		.md_done (md_done)
	);

	always #50 clk = ~clk;                     // 100 ns period

	function automatic logic [xlen-1:0] model_y(alu_op_e f_op, logic [xlen-1:0] x,
		logic [xlen-1:0] z, logic [xlen-1:0] h, logic [xlen-1:0] l);
		logic [shamt_w-1:0] sh_imm;
		logic [shamt_w-1:0] sh_var;
		sh_imm = z[10:6];
		sh_var = z[4:0];
		case (f_op)
			op_and:  return x & z;
			op_or:   return x | z;
			op_xor:  return x ^ z;
			op_addu: return x + z;
			op_subu: return x - z;
			op_slt:  return {31'b0, $signed(x) < $signed(z)};
			op_sltu: return {31'b0, x < z};
			op_lui:  return {z[15:0], 16'h0000};
			op_sll:  return x << sh_imm;
			op_sllv: return x << sh_var;
			op_srl:  return x >> sh_imm;
			op_srlv: return x >> sh_var;
			op_sra:  return $signed(x) >>> sh_imm;
			op_srav: return $signed(x) >>> sh_var;
			op_mfhi: return h;
			op_mflo: return l;
			default: return '0;                // Mul/div start codes
		endcase
	endfunction

	function automatic logic model_taken(branch_op_e f_br, logic [xlen-1:0] x,
		logic [xlen-1:0] z);
		case (f_br)
			br_beq:  return x == z;
			br_bne:  return x != z;
			br_blez: return $signed(x) <= 0;
			br_bgtz: return $signed(x) > 0;
			br_bltz: return $signed(x) < 0;
			default: return $signed(x) >= 0;
		endcase
	endfunction

	// Returns {hi, lo}
	function automatic logic [2*xlen-1:0] model_muldiv(alu_op_e f_op, logic [xlen-1:0] x,
		logic [xlen-1:0] z);
		longint sx;
		longint sz;
		sx = longint'($signed(x));
		sz = longint'($signed(z));
		case (f_op)
			op_mult:  return 64'(sx * sz);
			op_multu: return {32'b0, x} * {32'b0, z};
			op_div: begin
				if (z == '0) begin
					return {x, x[xlen-1] ? 32'h0000_0001 : 32'hffff_ffff};
				end
				return {32'(sx % sz), 32'(sx / sz)};   // 64-bit keeps min / -1 defined
			end
			default: begin
				if (z == '0) begin
					return {x, 32'hffff_ffff};
				end
				return {x % z, x / z};
			end
		endcase
	endfunction

	task automatic add_row(alu_op_e r_op, logic [xlen-1:0] r_a, logic [xlen-1:0] r_b,
		branch_op_e r_br = br_beq, logic r_poke = 1'b0);
		row_t            r;
		logic [2*xlen-1:0] res;
		r.op = r_op;
		r.br = r_br;
		r.a = r_a;
		r.b = r_b;
		r.start = r_op inside {op_mult, op_multu, op_div, op_divu};
		r.poke = r_poke;
		r.y = model_y(r_op, r_a, r_b, run_hi, run_lo);
		// Zero flag follows the ALU side, which reads 0 on shift codes
		r.zero = (r.y == '0) || (r_op inside {op_sll, op_sllv, op_srl, op_srlv, op_sra, op_srav});
		r.taken = model_taken(r_br, r_a, r_b);
		if (r.start) begin
			res = model_muldiv(r_op, r_a, r_b);
			run_hi = res[2*xlen-1:xlen];
			run_lo = res[xlen-1:0];
		end
		r.hi = run_hi;
		r.lo = run_lo;
		rows.push_back(r);
	endtask

	task automatic check_value(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic apply_row(int idx);
		row_t r;
		int   errs_before;
		int   edges;
		r = rows[idx];
		errs_before = errors;
		@(posedge clk);
		op <= r.op;
		br_op <= r.br;
		a <= r.a;
		b <= r.b;
		start <= r.start;
		@(negedge clk);
		check_value("y", y, r.y);
		check_value("zero", {31'b0, zero}, {31'b0, r.zero});
		check_value("taken", {31'b0, taken}, {31'b0, r.taken});
		if (r.start) begin
			edges = 0;
			do begin
				@(posedge clk);
				edges++;
				start <= (r.poke && edges == 10);
				if (r.poke && edges == 10) begin
					a <= ~r.a;                     // Must not reach the result
					b <= r.b ^ 32'h5a5a_5a5a;
				end
				@(negedge clk);
				if (!md_done) begin
					check_value("md_busy", {31'b0, md_busy}, 32'd1);
				end
			end while (!md_done && edges < 4 * muldiv_cycles);
			if (!md_done) begin
				errors++;
				$display("test %0d: md_done did not arrive within %0d cycles", idx, edges);
			end else begin
				check_value("md_done edge", edges, muldiv_cycles + 2);
				check_value("md_busy", {31'b0, md_busy}, 32'd0);
				@(posedge clk);
				op <= op_mfhi;
				@(negedge clk);
				check_value("hi", y, r.hi);
				@(posedge clk);
				op <= op_mflo;
				@(negedge clk);
				check_value("lo", y, r.lo);
			end
		end
		if (errors == errs_before) begin
			$display("test %0d %s: ok", idx, r.op.name());
		end else begin
			$display("test %0d %s: %0d errors", idx, r.op.name(), errors - errs_before);
		end
	endtask

	initial begin
		void'($urandom(32'h4cbf9a12));
		rst_n = 1'b0;
		op = op_and;
		a = '0;
		b = '0;
		start = 1'b0;
		br_op = br_beq;
		errors = 0;
		checks = 0;
		run_hi = '0;
		run_lo = '0;

		add_row(op_mfhi, 32'h0, 32'h0);           // Reset values
		add_row(op_mflo, 32'h0, 32'h0);
		add_row(op_and, 32'hf0f0_1234, 32'h0ff0_ff00);
		add_row(op_or, 32'hf0f0_1234, 32'h0ff0_ff00);
		add_row(op_xor, 32'hf0f0_1234, 32'hf0f0_1234);
		add_row(op_addu, 32'hffff_ffff, 32'h0000_0001);
		add_row(op_addu, 32'h7fff_ffff, 32'h0000_0001);
		add_row(op_subu, 32'h1234_5678, 32'h1234_5678);
		add_row(op_subu, 32'h0000_0000, 32'h0000_0001);
		add_row(op_lui, 32'h0, 32'hdead_1234);
		add_row(op_slt, 32'hffff_ffff, 32'h0000_0001);
		add_row(op_sltu, 32'hffff_ffff, 32'h0000_0001);
		add_row(op_slt, 32'h0000_0001, 32'h8000_0000);
		add_row(op_sltu, 32'h0000_0001, 32'h8000_0000);
		add_row(op_sll, 32'h8765_4321, 32'd0 << 6);
		add_row(op_sll, 32'h8765_4321, 32'd31 << 6);
		add_row(op_sll, 32'h0000_00ff, 32'hffff_f13f);
		add_row(op_sllv, 32'h8765_4321, 32'd0);
		add_row(op_sllv, 32'h8765_4321, 32'd31);
		add_row(op_sllv, 32'h8765_4321, 32'h25);  // Only b[4:0] counts
		add_row(op_srl, 32'h8765_4321, 32'd0 << 6);
		add_row(op_srl, 32'h8765_4321, 32'd31 << 6);
		add_row(op_srlv, 32'h8765_4321, 32'd4);
		add_row(op_srlv, 32'h8765_4321, 32'd31);
		add_row(op_sra, 32'h8000_0000, 32'd31 << 6);
		add_row(op_sra, 32'hf000_0000, 32'd4 << 6);
		add_row(op_sra, 32'h7000_0000, 32'd4 << 6);
		add_row(op_srav, 32'h8765_4321, 32'd0);
		add_row(op_srav, 32'h8765_4321, 32'h24);
		add_row(op_mult, 32'h8000_0000, 32'h8000_0000);
		add_row(op_mult, 32'hffff_ffff, 32'hffff_ffff);
		add_row(op_multu, 32'hffff_ffff, 32'hffff_ffff);
		add_row(op_multu, 32'h0000_0000, 32'h1234_5678);
		add_row(op_mult, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_mult, 32'h1234_5678, 32'h9abc_def0);
		add_row(op_mfhi, 32'h0, 32'h0);           // HI/LO hold after done
		add_row(op_div, 32'd7, 32'hffff_fffe);
		add_row(op_div, 32'hffff_fff9, 32'd2);
		add_row(op_div, 32'hffff_fff9, 32'hffff_fffe);
		add_row(op_divu, 32'hffff_ffff, 32'd7);
		add_row(op_div, 32'd5, 32'd0);
		add_row(op_div, 32'hffff_fffb, 32'd0);
		add_row(op_divu, 32'd5, 32'd0);
		add_row(op_div, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_divu, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_div, 32'd100, 32'd7, br_beq, 1'b1);
		for (int k = 0; k < 6; k++) begin
			for (int v = -1; v <= 1; v++) begin
				add_row(op_or, 32'(5 + v), 32'd5, branch_op_e'(3'(k)));
				add_row(op_or, 32'(7 * v), 32'd0, branch_op_e'(3'(k)));
			end
		end
		for (int i = 0; i < 40; i++) begin
			add_row(alu_op_e'(5'($urandom_range(19, 0))), $urandom(), $urandom(),
				branch_op_e'(3'($urandom_range(5, 0))));
		end

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
		end

		$display("tests %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- mips_execute.f
hdl/mips_exec_pkg.sv
hdl/alu_core.sv
hdl/barrel_shifter.sv
hdl/muldiv_unit.sv
hdl/branch_compare.sv
hdl/mips_execute.sv
tb/tb_mips_execute.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_mips_execute \
	-f mips_execute.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$log"; then
	exit 1
fi
if ! grep -q "TB PASSED" "$log"; then
	echo "No result line found in $log"
	exit 1
fi
exit 0
